// ==== Makefile ====
# verilator build and run of the bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_wb_axis_bridge
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "simulation gave no result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== list.f ====
src/ppfifo_pkg.sv
src/wb_ppfifo_writer.sv
src/ppfifo.sv
src/ppfifo_axis_adapter.sv
src/wb_axis_bridge_top.sv
verif/clk_gen.sv
verif/tb_wb_axis_bridge.sv

// ==== src/ppfifo.sv ====
// two-bank ping-pong fifo on a single clock
// writer and reader each own one bank at a time
// banks are handed over in commit order, reads are first-word fall-through

`timescale 1ns/1ps

module ppfifo (
  input  logic                              clk,
  input  logic                              rst,

  // write side
  output logic                              o_wr_rdy,
  input  logic                              i_wr_act,
  input  logic                              i_wr_stb,
  input  ppfifo_pkg::ppfifo_word_t          i_wr_word,

  // read side
  output logic                              o_rd_rdy,
  input  logic                              i_rd_act,
  input  logic                              i_rd_stb,
  output logic [ppfifo_pkg::SIZE_WIDTH-1:0] o_rd_size,
  output ppfifo_pkg::ppfifo_word_t          o_rd_word
);

  import ppfifo_pkg::*;

  // both banks in one array, bank select is the top address bit
  ppfifo_word_t          mem [2*FIFO_DEPTH];

  // per bank word count and committed flag
  logic [SIZE_WIDTH-1:0] count [2];
  logic [1:0]            filled;

  // banks alternate on both sides
  // rd_sel is the commit-order pointer
  logic                  wr_sel;
  logic                  rd_sel;

  // previous act levels, for take and hand-back edges
  logic                  wr_act_q;
  logic                  rd_act_q;

  logic [SIZE_WIDTH-1:0] rd_ptr;
  logic [SIZE_WIDTH-1:0] wr_addr;
  logic [SIZE_WIDTH-1:0] rd_addr;

  logic                  wr_push;
  logic                  wr_commit;
  logic                  rd_release;

  assign wr_push    = i_wr_act & i_wr_stb;
  assign wr_commit  = wr_act_q & ~i_wr_act;
  assign rd_release = rd_act_q & ~i_rd_act;

  // {bank, word index}
  assign wr_addr = {wr_sel, count[wr_sel][SIZE_WIDTH-2:0]};
  assign rd_addr = {rd_sel, rd_ptr[SIZE_WIDTH-2:0]};

  // next write bank is free and not held
  assign o_wr_rdy = ~wr_act_q & ~filled[wr_sel];

  // oldest committed bank waiting for the reader
  assign o_rd_rdy = filled[rd_sel] & ~rd_act_q;

  // fall-through read port
  assign o_rd_size = count[rd_sel];
  assign o_rd_word = mem[rd_addr];

  // storage
  always_ff @(posedge clk) begin
    if (wr_push) begin
      mem[wr_addr] <= i_wr_word;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count[0] <= '0;
      count[1] <= '0;
      filled   <= 2'b00;
      wr_sel   <= 1'b0;
      rd_sel   <= 1'b0;
      wr_act_q <= 1'b0;
      rd_act_q <= 1'b0;
      rd_ptr   <= '0;
    end else begin
      wr_act_q <= i_wr_act;
      rd_act_q <= i_rd_act;

      if (wr_push) begin
        count[wr_sel] <= count[wr_sel] + 1'b1;
      end

      // commit, an empty bank just stays with the writer side
      if (wr_commit && (count[wr_sel] != '0)) begin
        filled[wr_sel] <= 1'b1;
        wr_sel         <= ~wr_sel;
      end

      if (i_rd_stb) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      // release frees the bank, reader moves to the next one in order
      // never the bank the writer holds, that one is not filled
      if (rd_release) begin
        filled[rd_sel] <= 1'b0;
        count[rd_sel]  <= '0;
        rd_sel         <= ~rd_sel;
        rd_ptr         <= '0;
      end
    end
  end

  // writer auto-commit must keep pushes within the bank
  a_no_push_full: assert property (
    @(posedge clk) disable iff (rst)
    wr_push |-> (count[wr_sel] < SIZE_WIDTH'(FIFO_DEPTH))
  );

  // adapter strobes only inside its bank
  a_rd_in_range: assert property (
    @(posedge clk) disable iff (rst)
    i_rd_stb |-> (i_rd_act && (rd_ptr < o_rd_size))
  );

endmodule

// ==== src/ppfifo_axis_adapter.sv ====
// drains committed ping-pong fifo banks onto an axi stream
// stored user bit maps to the stream user, last on the final word of a bank

`timescale 1ns/1ps

module ppfifo_axis_adapter (
  input  logic                              clk,
  input  logic                              rst,

  // fifo read side
  input  logic                              i_rd_rdy,
  output logic                              o_rd_act,
  output logic                              o_rd_stb,
  input  logic [ppfifo_pkg::SIZE_WIDTH-1:0] i_rd_size,
  input  ppfifo_pkg::ppfifo_word_t          i_rd_word,

  // axi stream master
  input  logic                              i_axis_ready,
  output logic                              o_axis_valid,
  output ppfifo_pkg::axis_beat_t            o_axis_beat
);

  import ppfifo_pkg::*;

  adapter_state_e        state;
  logic [SIZE_WIDTH-1:0] beat_cnt;
  logic                  beat_fire;
  logic                  beat_final;

  assign beat_fire  = o_axis_valid & i_axis_ready;
  // bank is never empty, so size minus one does not wrap
  assign beat_final = (beat_cnt == i_rd_size - 1'b1);

  // every accepted beat pops the fifo
  assign o_rd_stb = beat_fire;

  // fall-through word goes out as is
  always_comb begin
    o_axis_beat.data = i_rd_word.data;
    o_axis_beat.user = i_rd_word.user;
    o_axis_beat.last = o_axis_valid & beat_final;
  end

  always_ff @(posedge clk) begin
    // valid is only held high from READY
    o_axis_valid <= 1'b0;
    if (rst) begin
      state    <= IDLE;
      o_rd_act <= 1'b0;
      beat_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          // act is already low here
          if (i_rd_rdy) begin
            beat_cnt <= '0;
            o_rd_act <= 1'b1;
            state    <= READY;
          end
        end
        READY: begin
          if (beat_cnt < i_rd_size) begin
            o_axis_valid <= 1'b1;
            if (beat_fire) begin
              beat_cnt <= beat_cnt + 1'b1;
              // stop right after the last beat
              if (beat_final) begin
                o_axis_valid <= 1'b0;
              end
            end
          end else begin
            // whole bank sent, hand it back
            o_rd_act <= 1'b0;
            state    <= RELEASE;
          end
        end
        RELEASE: begin
          // fifo sees the release this cycle
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // stalled beat holds until taken
  a_beat_stable: assert property (
    @(posedge clk) disable iff (rst)
    (o_axis_valid && !i_axis_ready) |=> (o_axis_valid && $stable(o_axis_beat))
  );

endmodule

// ==== src/ppfifo_pkg.sv ====
// shared widths and depth for the wishbone to axi stream bridge
// wishbone address map and adapter state encodings
// packed structs for bus requests, stored words and stream beats

package ppfifo_pkg;

  // data path widths
  localparam int DATA_WIDTH = 32;
  localparam int USER_WIDTH = 1;

  // words per bank
  localparam int FIFO_DEPTH = 16;

  // word count within one bank, 0 to FIFO_DEPTH inclusive
  localparam int SIZE_WIDTH = 5;

  // wishbone word address
  localparam int ADDR_WIDTH = 2;

  // wishbone register map
  typedef enum logic [ADDR_WIDTH-1:0] {
    // push with user 0
    ADR_DATA      = 2'd0,
    // push with user 1
    ADR_DATA_USER = 2'd1,
    // close the current block
    ADR_COMMIT    = 2'd2,
    // read only
    ADR_STATUS    = 2'd3
  } wb_addr_e;

  // stream adapter fsm
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    READY   = 2'd1,
    RELEASE = 2'd2
  } adapter_state_e;

  // wishbone classic request from the master
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [ADDR_WIDTH-1:0] adr;
    logic [DATA_WIDTH-1:0] dat;
  } wb_req_t;

  // one fifo entry, user bit above data
  typedef struct packed {
    logic [USER_WIDTH-1:0] user;
    logic [DATA_WIDTH-1:0] data;
  } ppfifo_word_t;

  // one stream beat
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [USER_WIDTH-1:0] user;
    logic                  last;
  } axis_beat_t;

endpackage

// ==== src/wb_axis_bridge_top.sv ====
// wishbone to axi stream bridge top level
// writer, ping-pong fifo and stream adapter in a chain

`timescale 1ns/1ps

module wb_axis_bridge_top (
  input  logic                              clk,
  input  logic                              rst,

  // wishbone classic slave
  input  ppfifo_pkg::wb_req_t               i_wb_req,
  output logic                              o_wb_ack,
  output logic [ppfifo_pkg::DATA_WIDTH-1:0] o_wb_dat,

  // axi stream master
  input  logic                              i_axis_ready,
  output logic                              o_axis_valid,
  output ppfifo_pkg::axis_beat_t            o_axis_beat
);

  import ppfifo_pkg::*;

  // write side
  logic                  wr_rdy;
  logic                  wr_act;
  logic                  wr_stb;
  ppfifo_word_t          wr_word;

  // read side
  logic                  rd_rdy;
  logic                  rd_act;
  logic                  rd_stb;
  logic [SIZE_WIDTH-1:0] rd_size;
  ppfifo_word_t          rd_word;

  wb_ppfifo_writer wb_ppfifo_writer_inst (
    .clk       (clk),
    .rst       (rst),
    .i_wb_req  (i_wb_req),
    .o_wb_ack  (o_wb_ack),
    .o_wb_dat  (o_wb_dat),
    .i_wr_rdy  (wr_rdy),
    .o_wr_act  (wr_act),
    .o_wr_stb  (wr_stb),
    .o_wr_word (wr_word)
  );

  ppfifo ppfifo_inst (
    .clk       (clk),
    .rst       (rst),
    .o_wr_rdy  (wr_rdy),
    .i_wr_act  (wr_act),
    .i_wr_stb  (wr_stb),
    .i_wr_word (wr_word),
    .o_rd_rdy  (rd_rdy),
    .i_rd_act  (rd_act),
    .i_rd_stb  (rd_stb),
    .o_rd_size (rd_size),
    .o_rd_word (rd_word)
  );

  ppfifo_axis_adapter ppfifo_axis_adapter_inst (
    .clk          (clk),
    .rst          (rst),
    .i_rd_rdy     (rd_rdy),
    .o_rd_act     (rd_act),
    .o_rd_stb     (rd_stb),
    .i_rd_size    (rd_size),
    .i_rd_word    (rd_word),
    .i_axis_ready (i_axis_ready),
    .o_axis_valid (o_axis_valid),
    .o_axis_beat  (o_axis_beat)
  );

endmodule

// ==== src/wb_ppfifo_writer.sv ====
// wishbone classic slave on the write side of the ping-pong fifo
// takes free banks, pushes data words with a user bit, commits blocks
// and answers status reads

`timescale 1ns/1ps

module wb_ppfifo_writer (
  input  logic                              clk,
  input  logic                              rst,

  // wishbone classic slave
  input  ppfifo_pkg::wb_req_t               i_wb_req,
  output logic                              o_wb_ack,
  output logic [ppfifo_pkg::DATA_WIDTH-1:0] o_wb_dat,

  // fifo write side
  input  logic                              i_wr_rdy,
  output logic                              o_wr_act,
  output logic                              o_wr_stb,
  output ppfifo_pkg::ppfifo_word_t          o_wr_word
);

  import ppfifo_pkg::*;

  wb_addr_e              adr;
  logic                  wb_access;
  logic                  wb_write;
  logic                  data_write;
  logic                  data_push;
  logic                  commit_req;
  logic                  auto_commit;
  logic [SIZE_WIDTH-1:0] word_cnt;
  logic [DATA_WIDTH-1:0] status_word;

  assign adr = wb_addr_e'(i_wb_req.adr);

  // ack is registered, so the access cycle with ack high is not a new one
  assign wb_access = i_wb_req.cyc & i_wb_req.stb & ~o_wb_ack;
  assign wb_write  = wb_access & i_wb_req.we;

  // data writes go straight through to the fifo
  assign data_write = wb_write & ((adr == ADR_DATA) | (adr == ADR_DATA_USER));
  // only while a bank is held, otherwise wait states
  assign data_push  = data_write & o_wr_act;

  // empty commits are dropped
  assign commit_req  = wb_write & (adr == ADR_COMMIT) & o_wr_act & (word_cnt != '0);
  // last word of a full bank closes it
  assign auto_commit = data_push & (word_cnt == SIZE_WIDTH'(FIFO_DEPTH - 1));

  assign o_wr_stb = data_push;

  always_comb begin
    o_wr_word.user = (adr == ADR_DATA_USER);
    o_wr_word.data = i_wb_req.dat;
  end

  // status register layout
  always_comb begin
    status_word                 = '0;
    status_word[0]              = o_wr_act;
    status_word[8 +: SIZE_WIDTH] = word_cnt;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_wb_ack <= 1'b0;
      o_wr_act <= 1'b0;
      word_cnt <= '0;
    end else begin
      // data writes without a bank hold the bus
      o_wb_ack <= wb_access & (~data_write | o_wr_act);

      if (!o_wr_act && i_wr_rdy) begin
        // grab the free bank
        o_wr_act <= 1'b1;
      end else if (commit_req || auto_commit) begin
        // falling act hands the bank to the reader
        o_wr_act <= 1'b0;
        word_cnt <= '0;
      end else if (data_push) begin
        word_cnt <= word_cnt + 1'b1;
      end
    end
  end

  // read data, status only at ADR_STATUS
  always_ff @(posedge clk) begin
    if (wb_access) begin
      if (!i_wb_req.we && (adr == ADR_STATUS)) begin
        o_wb_dat <= status_word;
      end else begin
        o_wb_dat <= '0;
      end
    end
  end

  // single-cycle ack per access
  a_ack_single: assert property (
    @(posedge clk) disable iff (rst)
    o_wb_ack |=> !o_wb_ack
  );

endmodule

// ==== verif/clk_gen.sv ====
// testbench clock source and power-on reset pulse

`timescale 1ns/1ps

module clk_gen (
  output logic o_clk,
  output logic o_rst
);

  // 4 ns period
  localparam int HALF_PERIOD_NS = 2;
  localparam int RESET_CYCLES   = 4;

  initial begin
    o_clk = 1'b0;
    forever #(HALF_PERIOD_NS) o_clk = ~o_clk;
  end

  // release just after an edge, like the other stimulus
  initial begin
    o_rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #1;
    o_rst = 1'b0;
  end

endmodule

// ==== verif/tb_wb_axis_bridge.sv ====
// testbench for the wishbone to axi stream bridge
// lcg stimulus, wishbone driver tasks, queue model of expected beats
// stream monitor and watchdog

`timescale 1ns/1ps

module tb_wb_axis_bridge;

  import ppfifo_pkg::*;

  localparam int N_BLOCKS    = 12;
  // two random phases, auto-commit block, status block, stall test
  localparam int MAX_WORDS   = 2 * N_BLOCKS * FIFO_DEPTH + 4 * FIFO_DEPTH;
  localparam int WATCHDOG_NS = MAX_WORDS * 40 + 4000;
  localparam int ACK_LIMIT   = 200;
  localparam int DRAIN_LIMIT = 2000;
  localparam int STALL_WAIT  = 50;
  localparam int DRIVE_DLY   = 1;

  logic                  clk;
  logic                  rst;
  wb_req_t               wb_req;
  logic                  wb_ack;
  logic [DATA_WIDTH-1:0] wb_dat;
  logic                  axis_ready;
  logic                  axis_valid;
  axis_beat_t            axis_beat;

  // ready pattern, 0 high, 1 random, 2 held low
  int                    ready_mode;
  logic [31:0]           stim_state;
  logic [31:0]           ready_state;

  // model, words of the open block and beats expected in order
  ppfifo_word_t          blk_q[$];
  axis_beat_t            exp_q[$];

  int                    n_beats;
  int                    mon_errors;
  int                    drv_errors;

  clk_gen clk_gen_inst (
    .o_clk (clk),
    .o_rst (rst)
  );

  wb_axis_bridge_top wb_axis_bridge_top_inst (
    .clk          (clk),
    .rst          (rst),
    .i_wb_req     (wb_req),
    .o_wb_ack     (wb_ack),
    .o_wb_dat     (wb_dat),
    .i_axis_ready (axis_ready),
    .o_axis_valid (axis_valid),
    .o_axis_beat  (axis_beat)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_rand();
    stim_state = lcg_step(stim_state);
    return stim_state;
  endfunction

  task automatic next_cycles(input int n);
    repeat (n) @(posedge clk);
    #(DRIVE_DLY);
  endtask

  task automatic bus_start(input logic we, input wb_addr_e adr, input logic [31:0] dat);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = dat;
  endtask

  // returns at drive time of the ack cycle, or after limit cycles
  task automatic bus_wait(input int limit, output logic acked, output logic [31:0] rdata);
    int n;
    acked = 1'b0;
    rdata = '0;
    n = 0;
    while (!acked && n < limit) begin
      next_cycles(1);
      n++;
      acked = wb_ack;
      rdata = wb_dat;
    end
  endtask

  task automatic bus_access(input logic we, input wb_addr_e adr, input logic [31:0] dat,
                            output logic [31:0] rdata);
    logic acked;
    bus_start(we, adr, dat);
    bus_wait(ACK_LIMIT, acked, rdata);
    wb_req = '0;
    if (!acked) begin
      $display("no ack for access to address %0d at t=%0t", adr, $time);
      drv_errors++;
    end
  endtask

  // block ends here, last on its final word
  task automatic close_block();
    axis_beat_t b;
    for (int i = 0; i < blk_q.size(); i++) begin
      b.data = blk_q[i].data;
      b.user = blk_q[i].user;
      b.last = (i == blk_q.size() - 1);
      exp_q.push_back(b);
    end
    blk_q.delete();
  endtask

  // a full bank closes without a commit
  task automatic push_word(input ppfifo_word_t w);
    blk_q.push_back(w);
    if (blk_q.size() == FIFO_DEPTH) begin
      close_block();
    end
  endtask

  task automatic write_word(input logic user);
    logic [31:0] rd;
    ppfifo_word_t w;
    w.user = user;
    w.data = next_rand();
    bus_access(1'b1, user ? ADR_DATA_USER : ADR_DATA, w.data, rd);
    push_word(w);
  endtask

  // empty commit adds no beats
  task automatic commit_block();
    logic [31:0] rd;
    bus_access(1'b1, ADR_COMMIT, '0, rd);
    close_block();
  endtask

  task automatic send_block(input int len);
    logic [31:0] r;
    for (int i = 0; i < len; i++) begin
      r = next_rand();
      write_word(r[30]);
    end
    commit_block();
  endtask

  // bank bit set, count in bits 8 up
  task automatic check_status(input int k);
    logic [31:0] rd;
    logic [31:0] expv;
    bus_access(1'b0, ADR_STATUS, '0, rd);
    expv = '0;
    expv[0] = 1'b1;
    expv[8 +: SIZE_WIDTH] = SIZE_WIDTH'(k);
    if (rd !== expv) begin
      $display("FAILED t=%0t o_wb_dat got %h expected %h", $time, rd, expv);
      drv_errors++;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (n_beats < exp_q.size() && n < DRAIN_LIMIT) begin
      next_cycles(1);
      n++;
    end
    if (n_beats < exp_q.size()) begin
      $display("stream stalled with %0d beats outstanding at t=%0t",
               exp_q.size() - n_beats, $time);
      drv_errors++;
    end
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expv);
    $display("FAILED t=%0t %s got %h expected %h", $time, name, got, expv);
    mon_errors++;
  endtask

  // ready pattern, own lcg state
  initial begin
    int mode;
    axis_ready  = 1'b0;
    ready_state = 32'hc0e2_3711;
    forever begin
      @(posedge clk);
      // mode sampled at the edge, changes land at drive time
      mode = ready_mode;
      #(DRIVE_DLY);
      ready_state = lcg_step(ready_state);
      if (mode == 0) begin
        axis_ready = 1'b1;
      end else if (mode == 1) begin
        axis_ready = ready_state[31];
      end else begin
        axis_ready = 1'b0;
      end
    end
  end

  // inputs are steady from drive time to the next edge, so handshakes are seen here
  always @(negedge clk) begin
    if (!rst && axis_valid && axis_ready) begin
      if (n_beats >= exp_q.size()) begin
        $display("unexpected beat with data %h at t=%0t", axis_beat.data, $time);
        mon_errors++;
      end else begin
        if (axis_beat.data !== exp_q[n_beats].data) begin
          report_mismatch("o_axis_beat.data", axis_beat.data, exp_q[n_beats].data);
        end
        if (axis_beat.user !== exp_q[n_beats].user) begin
          report_mismatch("o_axis_beat.user", 32'(axis_beat.user), 32'(exp_q[n_beats].user));
        end
        if (axis_beat.last !== exp_q[n_beats].last) begin
          report_mismatch("o_axis_beat.last", 32'(axis_beat.last), 32'(exp_q[n_beats].last));
        end
        n_beats++;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    logic [31:0]  r;
    logic [31:0]  rd;
    logic         acked;
    ppfifo_word_t w;
    int           k;
    wb_req     = '0;
    ready_mode = 0;
    stim_state = 32'hc0e2_3711;
    n_beats    = 0;
    mon_errors = 0;
    drv_errors = 0;
    @(negedge rst);
    next_cycles(3);
    check_status(0);

    // random lengths, ready high
    for (int b = 0; b < N_BLOCKS; b++) begin
      r = next_rand();
      send_block(int'(r[31:28]) + 1);
    end
    wait_drain();

    // random back-pressure
    ready_mode = 1;
    for (int b = 0; b < N_BLOCKS; b++) begin
      r = next_rand();
      send_block(int'(r[31:28]) + 1);
    end
    wait_drain();

    // full bank without commit, then empty commits
    ready_mode = 0;
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      r = next_rand();
      write_word(r[30]);
    end
    commit_block();
    commit_block();
    wait_drain();

    // word count in status
    r = next_rand();
    k = int'(r[27:24]) % 15 + 1;
    for (int i = 0; i < k; i++) begin
      r = next_rand();
      write_word(r[30]);
    end
    check_status(k);
    commit_block();
    wait_drain();

    // ready low, both banks committed, a third block has to wait
    ready_mode = 2;
    next_cycles(2);
    for (int i = 0; i < 2 * FIFO_DEPTH; i++) begin
      r = next_rand();
      write_word(r[30]);
    end
    w.user = 1'b1;
    w.data = next_rand();
    bus_start(1'b1, ADR_DATA_USER, w.data);
    bus_wait(STALL_WAIT, acked, rd);
    if (acked) begin
      $display("data write acked at t=%0t while both banks were committed", $time);
      drv_errors++;
    end else begin
      ready_mode = 0;
      bus_wait(ACK_LIMIT, acked, rd);
      if (!acked) begin
        $display("stalled data write never completed after ready rose, t=%0t", $time);
        drv_errors++;
      end
    end
    wb_req     = '0;
    ready_mode = 0;
    push_word(w);
    commit_block();
    wait_drain();

    // nothing more may come out
    next_cycles(20);
    if (n_beats != exp_q.size() || blk_q.size() != 0) begin
      $display("model out of step, %0d beats seen, %0d expected, %0d words open",
               n_beats, exp_q.size(), blk_q.size());
      drv_errors++;
    end

    $display("beats checked %0d, stream errors %0d, bus errors %0d",
             n_beats, mon_errors, drv_errors);
    if (mon_errors == 0 && drv_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
